// ==== design/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

  localparam int word_width  = 16;
  localparam int total_buses = 4;
  localparam int stack_depth = 8;

  localparam int depth_width   = $clog2(stack_depth + 1); // counts 0..stack_depth
  localparam int ptr_width     = $clog2(stack_depth);
  localparam int bus_sel_width = $clog2(total_buses);

  // data stack opcodes
  localparam logic [7:0] i_nop   = 8'h00;
  localparam logic [7:0] i_pushi = 8'h01;
  localparam logic [7:0] i_drop  = 8'h02;

  // immediate jumps and branches
  localparam logic [7:0] i_calli = 8'h20;
  localparam logic [7:0] i_jmpi  = 8'h21;
  localparam logic [7:0] i_bra   = 8'h22;
  localparam logic [7:0] i_bc    = 8'h23;
  localparam logic [7:0] i_bnc   = 8'h24;
  localparam logic [7:0] i_bo    = 8'h25;
  localparam logic [7:0] i_bno   = 8'h26;
  localparam logic [7:0] i_bi    = 8'h27;
  localparam logic [7:0] i_bni   = 8'h28;

  // compare second against top
  localparam logic [7:0] i_beq   = 8'h29;
  localparam logic [7:0] i_bne   = 8'h2a;
  localparam logic [7:0] i_bles  = 8'h2b;
  localparam logic [7:0] i_bleq  = 8'h2c;
  localparam logic [7:0] i_blesu = 8'h2d;
  localparam logic [7:0] i_blequ = 8'h2e;

  // stack jumps
  localparam logic [7:0] i_call  = 8'h2f;
  localparam logic [7:0] i_jmp   = 8'h30;

  // tests on top alone
  localparam logic [7:0] i_bz    = 8'h31;
  localparam logic [7:0] i_bnz   = 8'h32;
  localparam logic [7:0] i_ba    = 8'h33; // receiver_sends[top]
  localparam logic [7:0] i_bna   = 8'h34;

endpackage

// ==== design/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

  typedef struct packed {
    logic carry;
    logic overflow;
    logic interrupt;
  } status_t;

  typedef struct packed {
    logic                                valid;
    logic [7:0]                          opcode;
    logic [cpu_isa_pkg::word_width-1:0]  immediate;
    status_t                             status;
    logic [cpu_isa_pkg::total_buses-1:0] receiver_sends;
    logic                                push_imm;
    logic                                pop_one;
    logic                                push_return;        // calli
    logic                                replace_top_return; // call swaps the target for the return
    logic                                needs_one;
    logic                                needs_two;
  } decoded_t;

  typedef struct packed {
    logic [cpu_isa_pkg::word_width-1:0]  top;
    logic [cpu_isa_pkg::word_width-1:0]  second;
    logic [cpu_isa_pkg::depth_width-1:0] depth;
  } stack_view_t;

  typedef struct packed {
    logic branch;
    logic jump_immediate;
    logic jump_stack;
  } flow_t;

endpackage

// ==== design/instruction_decoder.sv ====
module instruction_decoder (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                instr_strobe,
  input  logic [7:0]                          instruction,
  input  logic [cpu_isa_pkg::word_width-1:0]  immediate,
  input  logic                                carry,
  input  logic                                overflow,
  input  logic                                interrupt,
  input  logic [cpu_isa_pkg::total_buses-1:0] receiver_sends,
  output cpu_bus_pkg::decoded_t               decoded
);
  import cpu_isa_pkg::*;

  logic push_imm;
  logic pop_one;
  logic push_return;
  logic replace_top_return;
  logic needs_one;
  logic needs_two;

  // stack actions and operand needs are decoded once here
  always_comb begin
    push_imm           = 1'b0;
    pop_one            = 1'b0;
    push_return        = 1'b0;
    replace_top_return = 1'b0;
    needs_one          = 1'b0;
    needs_two          = 1'b0;
    case (instruction)
      i_pushi: push_imm = 1'b1;
      i_drop: begin
        pop_one   = 1'b1;
        needs_one = 1'b1;
      end
      i_calli: push_return = 1'b1;
      i_call: begin
        replace_top_return = 1'b1;
        needs_one          = 1'b1;
      end
      i_jmp: begin
        pop_one   = 1'b1; // target leaves the stack
        needs_one = 1'b1;
      end
      i_beq, i_bne, i_bles, i_bleq, i_blesu, i_blequ: needs_two = 1'b1;
      i_bz, i_bnz, i_ba, i_bna: needs_one = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      decoded.valid <= 1'b0;
    end else begin
      decoded.valid <= instr_strobe;
    end
    if (instr_strobe) begin
      decoded.opcode             <= instruction;
      decoded.immediate          <= immediate;
      decoded.status             <= {carry, overflow, interrupt};
      decoded.receiver_sends     <= receiver_sends; // sampled with the strobe
      decoded.push_imm           <= push_imm;
      decoded.pop_one            <= pop_one;
      decoded.push_return        <= push_return;
      decoded.replace_top_return <= replace_top_return;
      decoded.needs_one          <= needs_one;
      decoded.needs_two          <= needs_two;
    end
  end

endmodule

// ==== design/data_stack.sv ====
module data_stack (
  input  logic                               clk,
  input  logic                               reset,
  input  cpu_bus_pkg::decoded_t              decoded,
  input  logic [cpu_isa_pkg::word_width-1:0] return_addr,
  output cpu_bus_pkg::stack_view_t           view,
  output logic                               fault_next,
  output logic                               stack_fault,
  output logic [cpu_isa_pkg::word_width-1:0] stack_top
);
  import cpu_isa_pkg::*;

  logic [word_width-1:0]  entries [stack_depth];
  logic [depth_width-1:0] depth;
  logic [ptr_width-1:0]   push_idx;
  logic [ptr_width-1:0]   top_idx;
  logic [ptr_width-1:0]   second_idx;
  logic                   pushing;
  logic                   underflow;
  logic                   overflow;

  assign push_idx   = depth[ptr_width-1:0];
  assign top_idx    = push_idx - 1'b1; // wraps correctly at full depth
  assign second_idx = push_idx - 2'd2;

  assign view.depth  = depth;
  assign view.top    = (depth != '0) ? entries[top_idx] : '0;
  assign view.second = (depth > 1) ? entries[second_idx] : '0;
  assign stack_top   = view.top;

  assign pushing   = decoded.push_imm | decoded.push_return;
  assign underflow = (decoded.needs_one && depth == '0) || (decoded.needs_two && depth < 2);
  assign overflow  = pushing && depth == depth_width'(stack_depth);

  assign fault_next = decoded.valid & (underflow | overflow);

  always_ff @(posedge clk) begin
    if (reset) begin
      depth       <= '0;
      stack_fault <= 1'b0;
    end else begin
      stack_fault <= fault_next; // pulses alongside retire
      if (decoded.valid && !fault_next) begin
        if (pushing) begin
          depth <= depth + 1'b1;
        end else if (decoded.pop_one) begin
          depth <= depth - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (decoded.valid && !fault_next) begin
      if (decoded.push_imm) begin
        entries[push_idx] <= decoded.immediate;
      end else if (decoded.push_return) begin
        entries[push_idx] <= return_addr;
      end else if (decoded.replace_top_return) begin
        entries[top_idx] <= return_addr; // old top already consumed as target
      end
    end
  end

endmodule

// ==== design/flow_control.sv ====
module flow_control (
  input  cpu_bus_pkg::decoded_t    decoded,
  input  cpu_bus_pkg::stack_view_t view,
  output cpu_bus_pkg::flow_t       flow
);
  import cpu_isa_pkg::*;

  logic                  bus_sends;
  logic [word_width-1:0] top;
  logic [word_width-1:0] second;

  assign top    = view.top;
  assign second = view.second;

  // an index past the last bus reads as idle
  assign bus_sends = (top < total_buses) ?
                     decoded.receiver_sends[top[bus_sel_width-1:0]] : 1'b0;

  always_comb begin
    flow = '0;
    case (decoded.opcode)
      i_calli, i_jmpi: flow.jump_immediate = 1'b1;
      i_call, i_jmp:   flow.jump_stack = 1'b1;
      i_bra:   flow.branch = 1'b1;
      i_bc:    flow.branch = decoded.status.carry;
      i_bnc:   flow.branch = ~decoded.status.carry;
      i_bo:    flow.branch = decoded.status.overflow;
      i_bno:   flow.branch = ~decoded.status.overflow;
      i_bi:    flow.branch = decoded.status.interrupt;
      i_bni:   flow.branch = ~decoded.status.interrupt;
      i_beq:   flow.branch = second == top;
      i_bne:   flow.branch = second != top;
      i_bles:  flow.branch = $signed(second) < $signed(top);
      i_bleq:  flow.branch = $signed(second) <= $signed(top);
      i_blesu: flow.branch = second < top;
      i_blequ: flow.branch = second <= top;
      i_bz:    flow.branch = top == '0;
      i_bnz:   flow.branch = top != '0;
      i_ba:    flow.branch = bus_sends;
      i_bna:   flow.branch = ~bus_sends;
      default: ;
    endcase
  end

endmodule

// ==== design/program_counter.sv ====
module program_counter (
  input  logic                               clk,
  input  logic                               reset,
  input  cpu_bus_pkg::decoded_t              decoded,
  input  cpu_bus_pkg::stack_view_t           view,
  input  cpu_bus_pkg::flow_t                 flow,
  input  logic                               fault,
  output logic [cpu_isa_pkg::word_width-1:0] pc,
  output logic                               retire,
  output logic [cpu_isa_pkg::word_width-1:0] return_addr
);
  import cpu_isa_pkg::*;

  logic        [word_width-1:0] pc_plus_one;
  logic signed [word_width-1:0] offset;
  logic        [word_width-1:0] pc_next;

  assign pc_plus_one = pc + 1'b1;
  assign return_addr = pc_plus_one;
  assign offset      = $signed(decoded.immediate);

  // stack jump wins over immediate jump, then taken branch
  always_comb begin
    if (fault) begin
      pc_next = pc_plus_one;
    end else if (flow.jump_stack) begin
      pc_next = view.top;
    end else if (flow.jump_immediate) begin
      pc_next = decoded.immediate;
    end else if (flow.branch) begin
      pc_next = pc + offset;
    end else begin
      pc_next = pc_plus_one;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= '0;
      retire <= 1'b0;
    end else begin
      retire <= decoded.valid;
      if (decoded.valid) begin
        pc <= pc_next;
      end
    end
  end

endmodule

// ==== design/stack_sequencer.sv ====
module stack_sequencer (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                instr_strobe,
  input  logic [7:0]                          instruction,
  input  logic [cpu_isa_pkg::word_width-1:0]  immediate,
  input  logic                                carry,
  input  logic                                overflow,
  input  logic                                interrupt,
  input  logic [cpu_isa_pkg::total_buses-1:0] receiver_sends,
  output logic [cpu_isa_pkg::word_width-1:0]  pc,
  output logic                                retire,
  output logic [cpu_isa_pkg::word_width-1:0]  stack_top,
  output logic                                stack_fault
);
  import cpu_isa_pkg::*;
  import cpu_bus_pkg::*;

  decoded_t              decoded;
  stack_view_t           view;
  flow_t                 flow;
  logic [word_width-1:0] return_addr;
  logic                  fault_next;

  instruction_decoder u_decoder (
    .clk            (clk),
    .reset          (reset),
    .instr_strobe   (instr_strobe),
    .instruction    (instruction),
    .immediate      (immediate),
    .carry          (carry),
    .overflow       (overflow),
    .interrupt      (interrupt),
    .receiver_sends (receiver_sends),
    .decoded        (decoded)
  );

  data_stack u_stack (
    .clk         (clk),
    .reset       (reset),
    .decoded     (decoded),
    .return_addr (return_addr),
    .view        (view),
    .fault_next  (fault_next),
    .stack_fault (stack_fault),
    .stack_top   (stack_top)
  );

  flow_control u_flow (
    .decoded (decoded),
    .view    (view),
    .flow    (flow)
  );

  program_counter u_pc (
    .clk         (clk),
    .reset       (reset),
    .decoded     (decoded),
    .view        (view),
    .flow        (flow),
    .fault       (fault_next),
    .pc          (pc),
    .retire      (retire),
    .return_addr (return_addr)
  );

endmodule

// ==== testbench/stack_sequencer_checker.sv ====
module stack_sequencer_checker (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               instr_strobe,
  input  logic                               retire,
  input  logic [cpu_isa_pkg::word_width-1:0] pc,
  input  logic [cpu_isa_pkg::word_width-1:0] stack_top,
  input  logic                               stack_fault,
  output int                                 checked
);
  import cpu_isa_pkg::*;

  localparam string vector_file = "testbench/stack_sequencer_vectors.txt";

  typedef struct packed {
    logic [word_width-1:0] pc;
    logic [word_width-1:0] top;
    logic                  fault;
  } expect_t;

  expect_t    pending [$];
  int         mismatches;
  int         other_errors;
  logic [1:0] strobe_hist; // strobes seen on the last two falling edges

  initial begin : read_expected
    int                     fd;
    int                     fields;
    string                  line;
    logic [7:0]             instr;
    logic [word_width-1:0]  imm;
    logic [2:0]             flags;
    logic [total_buses-1:0] sends;
    logic [word_width-1:0]  exp_pc;
    logic [word_width-1:0]  exp_top;
    logic                   exp_fault;
    expect_t                entry;
    mismatches   = 0;
    other_errors = 0;
    checked      = 0;
    fd = $fopen(vector_file, "r");
    if (fd == 0) begin
      $display("checker could not open the vector file %s", vector_file);
      other_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        fields = $sscanf(line, "%h %h %h %h %h %h %h",
                         instr, imm, flags, sends, exp_pc, exp_top, exp_fault);
        if (fields == 7) begin
          entry.pc    = exp_pc;
          entry.top   = exp_top;
          entry.fault = exp_fault;
          pending.push_back(entry);
        end
      end
      $fclose(fd);
    end
  end

  task automatic compare_value(input string name, input logic [word_width-1:0] got,
                               input logic [word_width-1:0] want);
    if (got !== want) begin
      mismatches++;
      $display("Mismatch %s: got %h, expected %h (vector %0d)", name, got, want, checked);
    end
  endtask

  // outputs are sampled mid-cycle
  always @(negedge clk) begin : watch_retire
    expect_t exp;
    if (reset) begin
      strobe_hist = '0;
    end else begin
      if (retire !== strobe_hist[1]) begin
        other_errors++;
        if (retire) begin
          $display("retire at %0t without a strobe two cycles before", $time);
        end else begin
          $display("no retire at %0t two cycles after a strobe", $time);
        end
      end
      if (retire === 1'b1) begin
        if (pending.size() == 0) begin
          other_errors++;
          $display("retire at %0t with no pending vector", $time);
        end else begin
          exp = pending.pop_front();
          compare_value("pc", pc, exp.pc);
          compare_value("stack_top", stack_top, exp.top);
          compare_value("stack_fault", word_width'(stack_fault), word_width'(exp.fault));
          checked++;
        end
      end
      strobe_hist = {strobe_hist[0], instr_strobe};
    end
  end

  task report_results(output int errors);
    if (pending.size() != 0) begin
      other_errors++;
      $display("%0d vectors were never retired", pending.size());
    end
    errors = mismatches + other_errors;
    $display("checker: %0d vectors checked, %0d mismatches, %0d other errors",
             checked, mismatches, other_errors);
  endtask

endmodule

// ==== testbench/tb_stack_sequencer.sv ====
module tb_stack_sequencer;
  import cpu_isa_pkg::*;

  localparam int    clk_period   = 20;
  localparam int    reset_cycles = 10;
  localparam string vector_file  = "testbench/stack_sequencer_vectors.txt";

  logic                   clk;
  logic                   reset;
  logic                   instr_strobe;
  logic [7:0]             instruction;
  logic [word_width-1:0]  immediate;
  logic                   carry;
  logic                   overflow;
  logic                   interrupt;
  logic [total_buses-1:0] receiver_sends;
  logic [word_width-1:0]  pc;
  logic                   retire;
  logic [word_width-1:0]  stack_top;
  logic                   stack_fault;

  logic [7:0]             vec_instr [$];
  logic [word_width-1:0]  vec_imm [$];
  logic [2:0]             vec_flags [$];
  logic [total_buses-1:0] vec_sends [$];
  int                     n_vectors;
  int                     burst_start;
  int                     checked;
  bit                     loaded;

  stack_sequencer dut0 (
    .clk            (clk),
    .reset          (reset),
    .instr_strobe   (instr_strobe),
    .instruction    (instruction),
    .immediate      (immediate),
    .carry          (carry),
    .overflow       (overflow),
    .interrupt      (interrupt),
    .receiver_sends (receiver_sends),
    .pc             (pc),
    .retire         (retire),
    .stack_top      (stack_top),
    .stack_fault    (stack_fault)
  );

  stack_sequencer_checker check0 (
    .clk          (clk),
    .reset        (reset),
    .instr_strobe (instr_strobe),
    .retire       (retire),
    .pc           (pc),
    .stack_top    (stack_top),
    .stack_fault  (stack_fault),
    .checked      (checked)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // keeps only the stimulus columns
  task automatic load_vectors(output bit opened);
    int                     fd;
    int                     fields;
    string                  line;
    logic [7:0]             instr;
    logic [word_width-1:0]  imm;
    logic [2:0]             flags;
    logic [total_buses-1:0] sends;
    logic [word_width-1:0]  exp_pc;
    logic [word_width-1:0]  exp_top;
    logic                   exp_fault;
    burst_start = -1;
    fd = $fopen(vector_file, "r");
    opened = (fd != 0);
    if (opened) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() >= 5 && line.substr(0, 4) == "burst") begin
          burst_start = vec_instr.size(); // no idle cycles from here on
        end else begin
          fields = $sscanf(line, "%h %h %h %h %h %h %h",
                           instr, imm, flags, sends, exp_pc, exp_top, exp_fault);
          if (fields == 7) begin
            vec_instr.push_back(instr);
            vec_imm.push_back(imm);
            vec_flags.push_back(flags);
            vec_sends.push_back(sends);
          end
        end
      end
      $fclose(fd);
    end
    n_vectors = vec_instr.size();
  endtask

  initial begin
    bit opened;
    int gap;
    int errors;
    reset          = 1'b1;
    instr_strobe   = 1'b0;
    instruction    = '0;
    immediate      = '0;
    carry          = 1'b0;
    overflow       = 1'b0;
    interrupt      = 1'b0;
    receiver_sends = '0;
    loaded         = 1'b0;
    void'($urandom(11797));
    load_vectors(opened);
    if (!opened) begin
      $display("could not open the vector file %s", vector_file);
      $display("TESTS FAILED");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      reset <= 1'b0;
      repeat (4) @(posedge clk); // idle cycles with retire low
      for (int i = 0; i < n_vectors; i++) begin
        gap = (burst_start < 0 || i < burst_start) ? $urandom_range(0, 2) : 0;
        repeat (gap) begin
          @(posedge clk);
          instr_strobe <= 1'b0;
        end
        @(posedge clk);
        instr_strobe   <= 1'b1;
        instruction    <= vec_instr[i];
        immediate      <= vec_imm[i];
        carry          <= vec_flags[i][2];
        overflow       <= vec_flags[i][1];
        interrupt      <= vec_flags[i][0];
        receiver_sends <= vec_sends[i];
      end
      @(posedge clk);
      instr_strobe <= 1'b0;
      wait (checked == n_vectors);
      repeat (4) @(posedge clk); // catch stray retires
      check0.report_results(errors);
      if (errors == 0) begin
        $display("TESTS PASSED");
      end else begin
        $display("TESTS FAILED");
      end
      $finish;
    end
  end

  initial begin
    int limit_cycles;
    int errors;
    wait (loaded);
    limit_cycles = n_vectors * 4 + reset_cycles + 50;
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the run did not complete within %0d cycles", limit_cycles);
    check0.report_results(errors);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== testbench/stack_sequencer_vectors.txt ====
// instruction immediate flags(carry overflow interrupt) receiver_sends
// expected pc, stack_top, stack_fault; all hex, a burst line starts back-to-back strobes
00 0000 0 0 0001 0000 0
30 0000 0 0 0002 0000 1
01 0005 0 0 0003 0005 0
29 0004 0 0 0004 0005 1
01 0007 0 0 0005 0007 0
02 0000 0 0 0006 0005 0
21 0040 0 0 0040 0005 0
22 0010 0 0 0050 0005 0
22 fff8 0 0 0048 0005 0
01 0060 0 0 0049 0060 0
30 0000 0 0 0060 0005 0
23 0004 4 0 0064 0005 0
23 0004 0 0 0065 0005 0
24 0004 0 0 0069 0005 0
24 0004 4 0 006a 0005 0
25 0004 2 0 006e 0005 0
25 0004 5 0 006f 0005 0
26 0004 5 0 0073 0005 0
26 0004 2 0 0074 0005 0
27 0004 1 0 0078 0005 0
27 0004 6 0 0079 0005 0
28 0004 6 0 007d 0005 0
28 0004 1 0 007e 0005 0
01 fffe 0 0 007f fffe 0
01 0003 0 0 0080 0003 0
2b 0004 0 0 0084 0003 0
2d 0004 0 0 0085 0003 0
2c 0004 0 0 0089 0003 0
2e 0004 0 0 008a 0003 0
29 0004 0 0 008b 0003 0
2a 0004 0 0 008f 0003 0
01 fffe 0 0 0090 fffe 0
2b 0004 0 0 0091 fffe 0
2d 0004 0 0 0095 fffe 0
2c 0004 0 0 0096 fffe 0
2e 0004 0 0 009a fffe 0
01 fffe 0 0 009b fffe 0
2b 0004 0 0 009c fffe 0
2c 0004 0 0 00a0 fffe 0
29 0004 0 0 00a4 fffe 0
2a 0004 0 0 00a5 fffe 0
31 0004 0 0 00a6 fffe 0
32 0004 0 0 00aa fffe 0
01 0000 0 0 00ab 0000 0
31 0004 0 0 00af 0000 0
32 0004 0 0 00b0 0000 0
33 0004 0 1 00b4 0000 0
33 0004 0 e 00b5 0000 0
34 0004 0 e 00b9 0000 0
34 0004 0 1 00ba 0000 0
01 0004 0 0 00bb 0004 0
33 0004 0 f 00bc 0004 0
34 0004 0 f 00c0 0004 0
01 0009 0 0 00c1 0009 0
01 0077 0 0 00c2 0009 1
02 0000 0 0 00c3 0004 0
20 0100 0 0 0100 00c4 0
2f 0000 0 0 00c4 0101 0
burst
02 0000 0 0 00c5 0004 0
02 0000 0 0 00c6 0000 0
01 0002 0 0 00c7 0002 0
32 0004 0 0 00cb 0002 0
01 0002 0 0 00cc 0002 0
29 0004 0 0 00d0 0002 0
02 0000 0 0 00d1 0002 0
30 0000 0 0 0002 0000 0
20 0200 0 0 0200 0003 0
2f 0000 0 0 0003 0201 0

// ==== compile.f ====
design/cpu_isa_pkg.sv
design/cpu_bus_pkg.sv
design/instruction_decoder.sv
design/data_stack.sv
design/flow_control.sv
design/program_counter.sv
design/stack_sequencer.sv
testbench/stack_sequencer_checker.sv
testbench/tb_stack_sequencer.sv
